//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = tb_ahb_pwm
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJDIR)

//--- compile.f
hw/pwm_pkg.sv
hw/pwm_reg_if.sv
hw/ahb_slave_fsm.sv
hw/pwm_regs.sv
hw/pwm_period_counter.sv
hw/pwm_output_stage.sv
hw/ahb_pwm_top.sv
testbench/ahb_pwm_chk.sv
testbench/tb_ahb_pwm.sv

//--- hw/ahb_pwm_top.sv
// AHB-Lite PWM peripheral top level joining bus FSM, registers, counter and output
`timescale 1ns/1ps

module ahb_pwm_top
    import pwm_pkg::*;
#(
    parameter int pwm_width = PWM_WIDTH_DEF
)(
    input   logic                       hclk,
    input   logic                       reset,
    input   logic   [AHB_DATA_W-1:0]    haddr_s,    // AHB HADDR
    input   logic   [AHB_DATA_W-1:0]    hwdata_s,   // AHB HWDATA
    output  logic   [AHB_DATA_W-1:0]    hrdata_s,   // AHB HRDATA
    input   logic                       hwrite_s,   // AHB HWRITE
    input   logic   [1:0]               htrans_s,   // AHB HTRANS
    input   logic   [2:0]               hsize_s,    // Not decoded
    input   logic   [2:0]               hburst_s,   // Not decoded
    output  logic   [1:0]               hresp_s,    // AHB HRESP
    output  logic                       hready_s,   // AHB HREADYOUT
    input   logic                       hsel_s,     // AHB HSEL
    output  logic                       pwm         // PWM pin
);

    logic                       enable;
    logic   [pwm_width-1:0]     period;
    logic   [pwm_width-1:0]     duty;
    logic   [pwm_width-1:0]     count;
    logic                       period_end;
    logic   [pwm_width-1:0]     period_active;

    pwm_reg_if #(.pwm_width(pwm_width)) reg_bus ();

    ahb_slave_fsm ahb_slave_fsm_inst (
        .hclk           ( hclk                      ),
        .reset          ( reset                     ),
        .haddr_s        ( haddr_s                   ),
        .hwdata_s       ( hwdata_s                  ),
        .hwrite_s       ( hwrite_s                  ),
        .htrans_s       ( ahb_htrans_e'(htrans_s)   ),
        .hsel_s         ( hsel_s                    ),
        .hready_s       ( hready_s                  ),
        .hresp_s        ( hresp_s                   ),
        .hrdata_s       ( hrdata_s                  ),
        .bus            ( reg_bus.ctrl              )
    );

    pwm_regs #(.pwm_width(pwm_width)) pwm_regs_inst (
        .hclk           ( hclk                      ),
        .reset          ( reset                     ),
        .count          ( count                     ),
        .bus            ( reg_bus.regs              ),
        .enable         ( enable                    ),
        .period         ( period                    ),
        .duty           ( duty                      )
    );

    pwm_period_counter #(.pwm_width(pwm_width)) pwm_period_counter_inst (
        .hclk           ( hclk                      ),
        .reset          ( reset                     ),
        .enable         ( enable                    ),
        .period_active  ( period_active             ),
        .count          ( count                     ),
        .period_end     ( period_end                )
    );

    pwm_output_stage #(.pwm_width(pwm_width)) pwm_output_stage_inst (
        .hclk           ( hclk                      ),
        .reset          ( reset                     ),
        .enable         ( enable                    ),
        .period         ( period                    ),
        .duty           ( duty                      ),
        .count          ( count                     ),
        .period_end     ( period_end                ),
        .period_active  ( period_active             ),
        .pwm            ( pwm                       )
    );

endmodule : ahb_pwm_top

//--- hw/ahb_slave_fsm.sv
// AHB-Lite slave FSM with address/data phase tracking and two-cycle ERROR response
`timescale 1ns/1ps

module ahb_slave_fsm
    import pwm_pkg::*;
(
    input   logic                       hclk,
    input   logic                       reset,
    input   logic   [AHB_DATA_W-1:0]    haddr_s,    // Address phase
    input   logic   [AHB_DATA_W-1:0]    hwdata_s,   // Data phase
    input   logic                       hwrite_s,
    input   ahb_htrans_e                htrans_s,
    input   logic                       hsel_s,
    output  logic                       hready_s,   // HREADYOUT
    output  ahb_hresp_e                 hresp_s,
    output  logic   [AHB_DATA_W-1:0]    hrdata_s,
    pwm_reg_if.ctrl                     bus
);

    ahb_state_e     state;
    ahb_state_e     state_next;
    logic           addr_phase;                     // Transfer accepted this edge
    logic           offset_legal;                   // Offset inside register file
    pwm_reg_e       reg_sel_q;                      // Latched word offset
    logic           write_q;                        // Latched HWRITE

    // Only NONSEQ and SEQ start a transfer, BUSY and IDLE are ignored
    assign addr_phase   = hsel_s && hready_s &&
                          ((htrans_s == HTRANS_NONSEQ) || (htrans_s == HTRANS_SEQ));
    assign offset_legal = haddr_s[PWM_WIN_W-1:0] < REG_SPACE;

    always_comb begin
        state_next = state;
        case (state)
            ST_ERROR_1: begin
                state_next = ST_ERROR_2;            // Second ERROR cycle always follows
            end
            default: begin                          // IDLE, DATA, ERROR_2 accept a new address
                if (addr_phase) begin
                    state_next = offset_legal ? ST_DATA : ST_ERROR_1;
                end else begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            write_q <= 1'b0;
        end else if (addr_phase) begin
            write_q <= hwrite_s;
        end
    end

    always_ff @(posedge hclk) begin
        if (addr_phase) begin
            reg_sel_q <= pwm_reg_e'(haddr_s[3:2]); // Word offset
        end
    end

    // Stall only in the first ERROR cycle
    assign hready_s = (state != ST_ERROR_1);
    assign hresp_s  = ((state == ST_ERROR_1) || (state == ST_ERROR_2)) ? HRESP_ERROR
                                                                       : HRESP_OKAY;

    assign bus.reg_sel = reg_sel_q;
    assign bus.we      = (state == ST_DATA) && write_q; // Register captures at end of DATA
    assign bus.wd      = hwdata_s;
    assign hrdata_s    = ((state == ST_DATA) && !write_q) ? bus.rd : '0;

endmodule : ahb_slave_fsm

//--- hw/pwm_output_stage.sv
// PWM output stage with period/duty shadow registers and the registered compare
`timescale 1ns/1ps

module pwm_output_stage
    import pwm_pkg::*;
#(
    parameter int pwm_width = PWM_WIDTH_DEF
)(
    input   logic                       hclk,
    input   logic                       reset,
    input   logic                       enable,
    input   logic   [pwm_width-1:0]     period,     // From PERIOD register
    input   logic   [pwm_width-1:0]     duty,       // From DUTY register
    input   logic   [pwm_width-1:0]     count,
    input   logic                       period_end,
    output  logic   [pwm_width-1:0]     period_active,
    output  logic                       pwm
);

    logic   [pwm_width-1:0]     period_sh;
    logic   [pwm_width-1:0]     duty_sh;

    // Reload only at a boundary so a period never mixes old and new values
    always_ff @(posedge hclk) begin
        if (reset) begin
            period_sh <= '0;
            duty_sh   <= '0;
        end else if (period_end || !enable) begin
            period_sh <= period;
            duty_sh   <= duty;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= enable && (count < duty_sh); // One register stage after compare
        end
    end

    assign period_active = period_sh;

endmodule : pwm_output_stage

//--- hw/pwm_period_counter.sv
// PWM period counter that wraps at the shadowed period and flags the period end
`timescale 1ns/1ps

module pwm_period_counter
    import pwm_pkg::*;
#(
    parameter int pwm_width = PWM_WIDTH_DEF
)(
    input   logic                       hclk,
    input   logic                       reset,
    input   logic                       enable,
    input   logic   [pwm_width-1:0]     period_active,  // Shadowed period
    output  logic   [pwm_width-1:0]     count,
    output  logic                       period_end      // High on the wrap cycle
);

    logic   [pwm_width-1:0]     last_tick;          // Final count of the period

    // Period 0 behaves as 1 so the counter stays at 0 and wraps every cycle
    assign last_tick  = (period_active == '0) ? '0 : period_active - pwm_width'(1);
    assign period_end = enable && (count == last_tick);

    always_ff @(posedge hclk) begin
        if (reset) begin
            count <= '0;
        end else if (!enable) begin
            count <= '0;                            // Held at 0 while disabled
        end else if (period_end) begin
            count <= '0;                            // Wrap
        end else begin
            count <= count + pwm_width'(1);
        end
    end

endmodule : pwm_period_counter

//--- hw/pwm_pkg.sv
// PWM peripheral package with bus encodings, register offsets and width constants
package pwm_pkg;

    localparam int AHB_DATA_W    = 32;                // HADDR / HWDATA / HRDATA width
    localparam int PWM_WIDTH_DEF = 8;                 // Default counter width
    localparam int PWM_WIN_W     = 12;                // 4 KB slave window

    // First offset outside the register file
    localparam logic [PWM_WIN_W-1:0] REG_SPACE = 12'h010;

    // AHB HTRANS encoding
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } ahb_htrans_e;

    // AHB HRESP encoding, kept at 2 bits like the system bus
    typedef enum logic [1:0] {
        HRESP_OKAY  = 2'b00,
        HRESP_ERROR = 2'b01
    } ahb_hresp_e;

    // Slave FSM states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_DATA    = 2'b01,
        ST_ERROR_1 = 2'b10,                           // Stall cycle of ERROR
        ST_ERROR_2 = 2'b11                            // Closing cycle of ERROR
    } ahb_state_e;

    // Register word offsets, HADDR[3:2]
    typedef enum logic [1:0] {
        REG_CTRL   = 2'b00,
        REG_PERIOD = 2'b01,
        REG_DUTY   = 2'b10,
        REG_COUNT  = 2'b11                            // Read only
    } pwm_reg_e;

endpackage : pwm_pkg

//--- hw/pwm_reg_if.sv
// Register access bus between the AHB slave FSM and the PWM register block
`timescale 1ns/1ps

interface pwm_reg_if
    import pwm_pkg::*;
#(
    parameter int pwm_width = PWM_WIDTH_DEF
)();

    pwm_reg_e                   reg_sel;            // Decoded word offset
    logic                       we;                 // One-cycle write strobe
    logic   [AHB_DATA_W-1:0]    wd;                 // Write data, full bus width
    logic   [pwm_width-1:0]     rd_reg;             // Register-side read value
    logic   [AHB_DATA_W-1:0]    rd;                 // Bus-side read data

    // Upper bits of every register read back as zero
    assign rd = {{(AHB_DATA_W - pwm_width){1'b0}}, rd_reg};

    modport ctrl (
        output  reg_sel,
        output  we,
        output  wd,
        input   rd
    );

    modport regs (
        input   reg_sel,
        input   we,
        input   wd,
        output  rd_reg
    );

endinterface : pwm_reg_if

//--- hw/pwm_regs.sv
// PWM register file with CTRL, PERIOD and DUTY storage and the read multiplexer
`timescale 1ns/1ps

module pwm_regs
    import pwm_pkg::*;
#(
    parameter int pwm_width = PWM_WIDTH_DEF
)(
    input   logic                       hclk,
    input   logic                       reset,
    input   logic   [pwm_width-1:0]     count,      // Live counter value
    pwm_reg_if.regs                     bus,
    output  logic                       enable,     // CTRL bit 0
    output  logic   [pwm_width-1:0]     period,
    output  logic   [pwm_width-1:0]     duty
);

    // Write side, upper data bits are dropped
    always_ff @(posedge hclk) begin
        if (reset) begin
            enable <= 1'b0;
            period <= '0;
            duty   <= '0;
        end else if (bus.we) begin
            case (bus.reg_sel)
                REG_CTRL: begin
                    enable <= bus.wd[0];
                end
                REG_PERIOD: begin
                    period <= bus.wd[pwm_width-1:0];
                end
                REG_DUTY: begin
                    duty <= bus.wd[pwm_width-1:0];
                end
                default: begin                      // COUNT write is ignored
                end
            endcase
        end
    end

    // Read side, combinational from the latched offset
    always_comb begin
        bus.rd_reg = '0;
        case (bus.reg_sel)
            REG_CTRL: begin
                bus.rd_reg[0] = enable;             // Only enable bit is implemented
            end
            REG_PERIOD: begin
                bus.rd_reg = period;
            end
            REG_DUTY: begin
                bus.rd_reg = duty;
            end
            REG_COUNT: begin
                bus.rd_reg = count;                 // Value in the data-phase cycle
            end
            default: begin
                bus.rd_reg = '0;
            end
        endcase
    end

endmodule : pwm_regs

//--- testbench/ahb_pwm_chk.sv
// Bound checker for the PWM peripheral ERROR sequence, stall length and disabled pin
`timescale 1ns/1ps

module ahb_pwm_chk
    import pwm_pkg::*;
(
    input   logic           hclk,
    input   logic           reset,
    input   logic           hready_s,
    input   logic   [1:0]   hresp_s,
    input   logic           enable,                 // CTRL bit 0
    input   logic           pwm
);

    int assert_fails = 0;                           // Failed assertions so far

    // Stall cycle of ERROR is closed by a ready ERROR cycle
    error_two_cycle: assert property (@(posedge hclk) disable iff (reset)
        (hresp_s == HRESP_ERROR && !hready_s) |=> (hresp_s == HRESP_ERROR && hready_s))
        else begin
            assert_fails++;
            $error("ERROR response was not closed by a ready ERROR cycle");
        end

    // Pin register follows enable one cycle later
    pwm_low_disabled: assert property (@(posedge hclk) disable iff (reset)
        !enable |=> !pwm)
        else begin
            assert_fails++;
            $error("pwm was high while CTRL was disabled");
        end

    stall_one_cycle: assert property (@(posedge hclk) disable iff (reset)
        !hready_s |=> hready_s)
        else begin
            assert_fails++;
            $error("hready_s stayed low for more than one cycle");
        end

endmodule : ahb_pwm_chk

bind ahb_pwm_top ahb_pwm_chk ahb_pwm_chk_inst (
    .hclk       ( hclk      ),
    .reset      ( reset     ),
    .hready_s   ( hready_s  ),
    .hresp_s    ( hresp_s   ),
    .enable     ( enable    ),
    .pwm        ( pwm       )
);

//--- testbench/tb_ahb_pwm.sv
// Testbench for the AHB-Lite PWM peripheral covering register access, duty cycle and ERROR
`timescale 1ns/1ps

module tb_ahb_pwm
    import pwm_pkg::*;
();

    localparam int          PWM_W        = 8;
    localparam int          BUS_TIMEOUT  = 8;           // Cycles allowed for one data phase
    localparam int          EDGE_TIMEOUT = 600;         // Longer than any period used
    localparam logic [31:0] PWM_MASK     = (32'd1 << PWM_W) - 32'd1;

    typedef struct {
        int period;
        int duty;
        int high;                                       // Expected high cycles per period
    } pwm_row_t;

    logic           hclk = 1'b0;
    logic           reset;
    logic   [31:0]  haddr_s;
    logic   [31:0]  hwdata_s;
    logic   [31:0]  hrdata_s;
    logic           hwrite_s;
    logic   [1:0]   htrans_s;
    logic   [2:0]   hsize_s;
    logic   [2:0]   hburst_s;
    logic   [1:0]   hresp_s;
    logic           hready_s;
    logic           hsel_s;
    logic           pwm;

    int             errors = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             errors_at_start;
    logic   [31:0]  rng_state = 32'd16;                 // Xorshift seed
    pwm_row_t       rows[$];

    always #10 hclk = ~hclk;                            // 20 ns period

    ahb_pwm_top #(.pwm_width(PWM_W)) ahb_pwm_top_inst (.*);

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endfunction

    function automatic void check_true(logic cond, string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endfunction

    task automatic test_begin();
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic test_end(string name);
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (16) @(posedge hclk);
        reset <= 1'b0;
        @(posedge hclk);
    endtask

    // Single transfer, address phase then data phase until hready
    task automatic bus_xfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic [1:0] first_resp, output logic [1:0] last_resp,
                            output int stalls);
        logic done;
        done       = 1'b0;
        stalls     = 0;
        rdata      = '0;
        first_resp = '0;
        last_resp  = '0;
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= HTRANS_NONSEQ;
        haddr_s  <= addr;
        hwrite_s <= write;
        @(posedge hclk);                                // Address phase taken here
        hsel_s   <= 1'b0;
        htrans_s <= HTRANS_IDLE;
        hwdata_s <= wdata;
        for (int i = 0; i < BUS_TIMEOUT && !done; i++) begin
            @(negedge hclk);
            if (i == 0) begin
                first_resp = hresp_s;
            end
            last_resp = hresp_s;
            if (hready_s) begin
                rdata = hrdata_s;                       // Data phase closes at next edge
                done  = 1'b1;
            end else begin
                stalls++;
            end
        end
        check_true(done, "timeout waiting for hready_s to end a data phase");
    endtask

    task automatic reg_write(input pwm_reg_e r, input logic [31:0] data);
        logic [31:0] rd;
        logic [1:0]  r1;
        logic [1:0]  r2;
        int          st;
        bus_xfer(1'b1, {28'h0, r, 2'b00}, data, rd, r1, r2, st);
        check_true(r2 == HRESP_OKAY && st == 0, "register write got ERROR or a stall");
    endtask

    task automatic reg_read(input pwm_reg_e r, output logic [31:0] data);
        logic [1:0]  r1;
        logic [1:0]  r2;
        int          st;
        bus_xfer(1'b0, {28'h0, r, 2'b00}, '0, data, r1, r2, st);
        check_true(r2 == HRESP_OKAY && st == 0, "register read got ERROR or a stall");
    endtask

    task automatic check_error_xfer(input logic write);
        logic [31:0] rd;
        logic [1:0]  r1;
        logic [1:0]  r2;
        int          st;
        bus_xfer(write, 32'h0000_0010, 32'hFFFF_FFFF, rd, r1, r2, st);
        check_value("hresp_s stall cycle", 32'(r1), 32'(HRESP_ERROR));
        check_value("hresp_s ready cycle", 32'(r2), 32'(HRESP_ERROR));
        check_value("hready_s low cycles", st, 1);
    endtask

    task automatic setup_pwm(input int period, input int duty);
        reg_write(REG_CTRL, 32'h0);                     // Shadows follow while disabled
        reg_write(REG_PERIOD, period);
        reg_write(REG_DUTY, duty);
        reg_write(REG_CTRL, 32'h1);
    endtask

    task automatic wait_rise();
        logic prev;
        logic found;
        prev  = pwm;
        found = 1'b0;
        for (int i = 0; i < EDGE_TIMEOUT && !found; i++) begin
            @(negedge hclk);
            found = pwm && !prev;
            prev  = pwm;
        end
        check_true(found, "timeout waiting for a rising edge on pwm");
    endtask

    // Starts on a rising-edge sample, ends on the next one
    task automatic count_period(output int highs, output int span);
        logic prev;
        logic done;
        highs = 1;
        span  = 1;
        prev  = 1'b1;
        done  = 1'b0;
        for (int i = 0; i < EDGE_TIMEOUT && !done; i++) begin
            @(negedge hclk);
            done = pwm && !prev;
            if (!done) begin
                highs += int'(pwm);
                span++;
            end
            prev = pwm;
        end
        check_true(done, "timeout waiting for the end of a pwm period");
    endtask

    task automatic sample_level(input int n, output int highs);
        highs = 0;
        repeat (n) begin
            @(negedge hclk);
            highs += int'(pwm);
        end
    endtask

    task automatic build_table();
        int p;
        int d;
        rows.push_back('{10, 3, 3});
        rows.push_back('{10, 0, 0});                    // Constantly low
        rows.push_back('{10, 10, 10});                  // Constantly high
        rows.push_back('{8, 12, 8});                    // Duty above period clips
        rows.push_back('{1, 1, 1});
        rows.push_back('{255, 128, 128});
        repeat (4) begin
            p = 2 + int'(next_random() % 32'd40);
            d = int'(next_random() % (32'(p) + 32'd4));
            rows.push_back('{p, d, (d < p) ? d : p});
        end
    endtask

    initial begin
        logic [31:0] rd0;
        logic [31:0] rd1;
        int          highs;
        int          highs_next;
        int          span;
        pwm_row_t    row;

        reset    = 1'b1;
        haddr_s  = '0;
        hwdata_s = '0;
        hwrite_s = 1'b0;
        htrans_s = HTRANS_IDLE;
        hsize_s  = 3'b010;                              // Word
        hburst_s = 3'b000;                              // Single
        hsel_s   = 1'b0;
        build_table();
        apply_reset();

        test_begin();
        reg_write(REG_PERIOD, 32'hABCD_1234);
        reg_read(REG_PERIOD, rd0);
        check_value("hrdata_s PERIOD", rd0, 32'hABCD_1234 & PWM_MASK);
        reg_write(REG_DUTY, 32'h0000_0F5A);
        reg_read(REG_DUTY, rd0);
        check_value("hrdata_s DUTY", rd0, 32'h0000_0F5A & PWM_MASK);
        reg_write(REG_CTRL, 32'hFFFF_FFFE);
        reg_read(REG_CTRL, rd0);
        check_value("hrdata_s CTRL", rd0, 32'h0);
        reg_write(REG_CTRL, 32'h0000_0003);
        reg_read(REG_CTRL, rd0);
        check_value("hrdata_s CTRL", rd0, 32'h1);
        test_end("register readback");

        test_begin();
        foreach (rows[k]) begin
            row = rows[k];
            setup_pwm(row.period, row.duty);
            repeat (row.period + 2) @(negedge hclk); // Let one full period pass
            if (row.high == 0 || row.high == row.period) begin
                sample_level(row.period, highs);        // Flat pin, no edges to find
            end else begin
                wait_rise();
                count_period(highs, span);
                check_value("pwm period cycles", span, row.period);
            end
            check_value("pwm high cycles", highs, row.high);
        end
        test_end("duty cycle table");

        test_begin();
        setup_pwm(20, 5);
        wait_rise();
        fork
            count_period(highs, span);
            begin
                repeat (3) @(posedge hclk);             // Mid-period DUTY change
                reg_write(REG_DUTY, 32'd12);
            end
        join
        count_period(highs_next, span);
        check_value("pwm high cycles in period of write", highs, 5);
        check_value("pwm high cycles in next period", highs_next, 12);
        test_end("boundary update");

        test_begin();
        reg_write(REG_CTRL, 32'h0);
        reg_write(REG_PERIOD, 32'h55);
        reg_write(REG_DUTY, 32'h22);
        check_error_xfer(1'b1);
        check_error_xfer(1'b0);
        reg_read(REG_CTRL, rd0);
        check_value("hrdata_s CTRL", rd0, 32'h0);
        reg_read(REG_PERIOD, rd0);
        check_value("hrdata_s PERIOD", rd0, 32'h55);
        reg_read(REG_DUTY, rd0);
        check_value("hrdata_s DUTY", rd0, 32'h22);
        test_end("ERROR response");

        test_begin();
        setup_pwm(50, 10);
        repeat (5) @(negedge hclk);
        reg_read(REG_COUNT, rd0);
        reg_read(REG_COUNT, rd1);
        check_true(rd0 != rd1, "two COUNT reads while enabled returned the same value");
        check_true(rd0 < 50 && rd1 < 50, "COUNT read back at or above the period");
        reg_write(REG_COUNT, 32'h77);                   // Read only, must be dropped
        reg_read(REG_PERIOD, rd0);
        check_value("hrdata_s PERIOD", rd0, 32'd50);
        reg_read(REG_DUTY, rd0);
        check_value("hrdata_s DUTY", rd0, 32'd10);
        reg_write(REG_CTRL, 32'h0);
        repeat (2) @(negedge hclk);
        check_value("pwm", 32'(pwm), 32'h0);
        reg_read(REG_COUNT, rd0);
        check_value("hrdata_s COUNT", rd0, 32'h0);
        test_end("disable and COUNT");

        errors += ahb_pwm_top_inst.ahb_pwm_chk_inst.assert_fails;
        $display("%0d tests run, %0d failed, %0d errors in total", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_ahb_pwm
